// File: tb/program_input.hex
// from @008: rom image, one instruction per line, opcode then operand bytes
// from @100: number of expected ram writes, then one address and data pair per line
@008
74 3C   // mov a,#3Ch
F5 20   // store 3C
24 D0   // add gives 0C with carry
F5 21
E5 D0   // psw into a, 80
F5 22
74 07
94 03   // subb with carry in gives 03
F5 23
94 05   // borrow gives FE
F5 24
E5 D0   // carry and odd parity, 81
F5 25
74 F0
54 3C   // anl 30
44 05   // orl 35
64 FF   // xrl CA
F5 26
04      // inc CB
F4      // cpl 34
F5 27
74 FF
04      // wraps to 00, carry stays set
E5 D0
F5 28
74 13
F5 F0   // b = 13, not on the bus
E5 20   // read back 3C
25 21   // 48
25 F0   // plus b, 5B
25 E0   // plus a, B6
F5 29
E5 D0   // carry clear and odd parity, 01
F5 2A
E5 F0
F5 2B
80 02   // jump over the next store
F5 2C
00
A5      // unknown opcode
F5 2D
80 FE   // jump to itself
@100
0D
20 3C
21 0C
22 80
23 03
24 FE
25 81
26 CA
27 34
28 80
29 B6
2A 01
2B 13
2D 13

// File: all.f
logic/cpu_pkg.sv
logic/alu.sv
logic/core_regs.sv
logic/insn_decoder.sv
logic/cpu_sequencer.sv
logic/cpu_top.sv
tb/mem_model.sv
tb/tb_cpu.sv

// File: run.sh
#!/bin/sh
# build with verilator and run, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_cpu -f all.f -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim > sim.log 2>&1 \
    || echo "Test FAILED" >> sim.log
cat sim.log
if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// File: tb/tb_cpu.sv
// --------------------
// runs the program from tb/program_input.hex, every ram write checked in order
// the program must end in a jump to itself so that no later store appears
// --------------------
`default_nettype none
`timescale 1ns/100ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam addr_t RESET_PC     = 16'h0008;
    localparam int    IDLE_CYCLES  = 6;
    localparam int    HALF_PERIOD  = 20;
    localparam int    DRIVE_DELAY  = 1;
    localparam int    RESET_CYCLES = 10;
    localparam int    EXP_BASE     = 256;   // write count, then address/data pairs
    localparam int    FIRST_LIMIT  = 50;    // cycles
    localparam int    RUN_LIMIT    = 3000;
    localparam int    QUIET_CYCLES = 200;   // watch for stray stores at the end

    logic  clk = 1'b0;
    logic  rst_n;
    addr_t mem_addr;
    logic  mem_sel;
    logic  mem_rd;
    logic  mem_wr;
    byte_t mem_wdata;
    byte_t mem_rdata;
    logic  wr_valid;
    byte_t wr_addr;
    byte_t wr_data;

    byte_t image [0:511];
    int    exp_count;
    int    wr_index;
    int    error_count;
    int    timeout_count;
    int    cycles;

    always #HALF_PERIOD clk = ~clk;

    cpu_top #(
        .reset_pc    (RESET_PC),
        .idle_cycles (IDLE_CYCLES)
    ) cpu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_sel   (mem_sel),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata)
    );

    mem_model #(
        .drive_delay (DRIVE_DELAY)
    ) mem_model_inst (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_sel   (mem_sel),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            error_count = error_count + 1;
            $display("FAILED time %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // one clock, then compare a write of that cycle with the next expected pair
    task automatic watch_cycle();
        @(negedge clk);
        if (mem_wr) begin
            check_value("mem_sel on write strobe", int'(mem_sel), 1);   // writes go to ram
        end
        if (wr_valid) begin
            if (wr_index < exp_count) begin
                check_value($sformatf("write %0d address", wr_index), int'(wr_addr),
                            int'(image[EXP_BASE + 1 + 2 * wr_index]));
                check_value($sformatf("write %0d data", wr_index), int'(wr_data),
                            int'(image[EXP_BASE + 2 + 2 * wr_index]));
            end else begin
                error_count = error_count + 1;
                $display("unexpected ram write at time %0t to address %0h with data %0h",
                         $time, wr_addr, wr_data);
            end
            wr_index = wr_index + 1;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        wr_index      = 0;
        error_count   = 0;
        timeout_count = 0;
        cycles        = 0;
        for (int i = 0; i < 512; i++) begin
            image[i] = byte'(i) ^ byte'(i >> 8);   // under the gaps of the file
        end
        $readmemh("tb/program_input.hex", image);
        exp_count = int'(image[EXP_BASE]);
        for (int i = 0; i < 256; i++) begin
            mem_model_inst.load_rom(byte'(i), image[i]);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // --------------------
        // quiet idle period, then the first fetch
        watch_cycle();
        while (!mem_rd && !mem_wr && cycles < FIRST_LIMIT) begin
            cycles = cycles + 1;
            watch_cycle();
        end
        if (cycles >= FIRST_LIMIT) begin
            timeout_count = timeout_count + 1;
            $display("timeout: no bus access within %0d cycles after reset", FIRST_LIMIT);
        end else begin
            check_value("idle cycles before first access", cycles, IDLE_CYCLES);
            check_value("mem_wr at first access", int'(mem_wr), 0);
            check_value("mem_sel at first access", int'(mem_sel), 0);
            check_value("first fetch address", int'(mem_addr), int'(RESET_PC));

            // --------------------
            // program run, all stores compared as they come
            cycles = 0;
            while (wr_index < exp_count && cycles < RUN_LIMIT) begin
                cycles = cycles + 1;
                watch_cycle();
            end
            if (wr_index < exp_count) begin
                timeout_count = timeout_count + 1;
                $display("timeout: only %0d of %0d expected writes seen", wr_index, exp_count);
            end else begin
                for (int n = 0; n < QUIET_CYCLES; n++) begin
                    watch_cycle();
                end
            end
        end

        $display("writes seen %0d, expected %0d, errors %0d, timeouts %0d",
                 wr_index, exp_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_model.sv
// --------------------
// 256-byte rom and ram behind the core bus, only the low address byte decodes
// read data follows one cycle after mem_rd, writes land in the strobe cycle
// --------------------
`default_nettype none
`timescale 1ns/100ps

module mem_model
    import cpu_pkg::*;
#(
    parameter int drive_delay = 1
) (
    input  logic  clk,
    input  addr_t mem_addr,
    input  logic  mem_sel,
    input  logic  mem_rd,
    input  logic  mem_wr,
    input  byte_t mem_wdata,
    output byte_t mem_rdata,
    output logic  wr_valid,    // high one cycle per write strobe
    output byte_t wr_addr,
    output byte_t wr_data
);

    byte_t rom [0:255];
    byte_t ram [0:255];

    logic  rd_req;
    logic  wr_req;
    logic  sel_q;
    byte_t addr_q;
    byte_t wdata_q;

    task automatic load_rom(input byte_t addr, input byte_t data);
        rom[addr] = data;
    endtask

    initial begin
        mem_rdata = '0;
        wr_valid  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = byte'(i) ^ 8'h5A;   // never read before written
        end
        // bus sampled mid-cycle, answer driven just after the next rising edge
        forever begin
            @(negedge clk);
            rd_req  = mem_rd;
            wr_req  = mem_wr;
            sel_q   = mem_sel;
            addr_q  = mem_addr[7:0];
            wdata_q = mem_wdata;
            @(posedge clk);
            #drive_delay;
            if (rd_req) mem_rdata = sel_q ? ram[addr_q] : rom[addr_q];
            if (wr_req && sel_q) ram[addr_q] = wdata_q;
            wr_valid = wr_req;
            wr_addr  = addr_q;
            wr_data  = wdata_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
// --------------------
// accumulator core top, single-cycle strobes and no back-pressure on the bus
// direct addresses E0h/F0h/D0h never appear on the bus
// --------------------
`default_nettype none
`timescale 1ns/100ps

module cpu_top
    import cpu_pkg::*;
#(
    parameter addr_t reset_pc    = 16'h0000,
    parameter int    idle_cycles = 6
) (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t mem_rdata,
    output addr_t mem_addr,
    output logic  mem_sel,    // 1 ram, 0 rom
    output logic  mem_rd,
    output logic  mem_wr,
    output byte_t mem_wdata
);

    // sequencer <-> decoder
    opcode_e   opcode;
    step_t     step;
    step_t     first_step;
    logic      need_rom;
    logic      need_ram_read;
    logic      need_execute;
    logic      need_ram_write;
    logic      is_idle;
    src_e      a_src;
    src_e      b_src;
    alu_op_e   alu_op;

    // datapath
    byte_t     rom_data;
    byte_t     ram_data;
    byte_t     dir_rdata;
    logic      dir_hit;
    logic      exec_stb;
    logic      wb_stb;
    dir_addr_t dir_addr;
    byte_t     a_val;
    byte_t     b_val;
    logic      cy;
    byte_t     alu_result;
    logic      alu_cy;

    cpu_sequencer #(
        .reset_pc    (reset_pc),
        .idle_cycles (idle_cycles)
    ) cpu_sequencer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_rdata      (mem_rdata),
        .opcode         (opcode),
        .step           (step),
        .first_step     (first_step),
        .need_rom       (need_rom),
        .need_ram_read  (need_ram_read),
        .need_execute   (need_execute),
        .need_ram_write (need_ram_write),
        .is_idle        (is_idle),
        .rom_data       (rom_data),
        .ram_data       (ram_data),
        .dir_rdata      (dir_rdata),
        .dir_hit        (dir_hit),
        .exec_stb       (exec_stb),
        .wb_stb         (wb_stb),
        .dir_addr       (dir_addr),
        .mem_addr       (mem_addr),
        .mem_sel        (mem_sel),
        .mem_rd         (mem_rd),
        .mem_wr         (mem_wr)
    );

    insn_decoder insn_decoder_inst (
        .opcode         (opcode),
        .step           (step),
        .first_step     (first_step),
        .need_rom       (need_rom),
        .need_ram_read  (need_ram_read),
        .need_execute   (need_execute),
        .need_ram_write (need_ram_write),
        .is_idle        (is_idle),
        .a_src          (a_src),
        .b_src          (b_src),
        .alu_op         (alu_op)
    );

    alu alu_inst (
        .a      (a_val),
        .b      (b_val),
        .cy_in  (cy),
        .op     (alu_op),
        .result (alu_result),
        .cy_out (alu_cy)
    );

    core_regs core_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_stb   (exec_stb),
        .wb_stb     (wb_stb),
        .a_src      (a_src),
        .b_src      (b_src),
        .rom_data   (rom_data),
        .ram_data   (ram_data),
        .dir_addr   (dir_addr),
        .alu_result (alu_result),
        .alu_cy     (alu_cy),
        .a_val      (a_val),
        .b_val      (b_val),
        .cy         (cy),
        .dir_hit    (dir_hit),
        .dir_rdata  (dir_rdata),
        .wdata      (mem_wdata)  // store data is always A
    );

endmodule

`default_nettype wire

// File: logic/cpu_sequencer.sv
// --------------------
// one instruction in flight; every bus slot is 2 cycles, strobe in the first
// idle_cycles must be at least 1
// --------------------
`default_nettype none
`timescale 1ns/100ps

module cpu_sequencer
    import cpu_pkg::*;
#(
    parameter addr_t reset_pc    = 16'h0000,
    parameter int    idle_cycles = 6
) (
    input  logic      clk,
    input  logic      rst_n,
    input  byte_t     mem_rdata,
    output opcode_e   opcode,
    output step_t     step,
    input  step_t     first_step,
    input  logic      need_rom,
    input  logic      need_ram_read,
    input  logic      need_execute,
    input  logic      need_ram_write,
    input  logic      is_idle,
    output byte_t     rom_data,
    output byte_t     ram_data,
    input  byte_t     dir_rdata,
    input  logic      dir_hit,
    output logic      exec_stb,
    output logic      wb_stb,
    output dir_addr_t dir_addr,
    output addr_t     mem_addr,
    output logic      mem_sel,
    output logic      mem_rd,
    output logic      mem_wr
);

    localparam int IDLE_W = $clog2(idle_cycles + 1);
    localparam logic [IDLE_W-1:0] IDLE_LOAD = IDLE_W'(idle_cycles - 1);

    seq_state_e        state_q;
    seq_state_e        state_d;
    logic              slot_q;      // second cycle of a bus slot
    addr_t             pc_q;
    byte_t             ir_q;
    byte_t             rom_q;
    byte_t             ram_q;
    step_t             step_q;
    logic [IDLE_W-1:0] idle_cnt_q;
    logic              bus_state;
    logic              rom_state;
    logic              ram_state;
    logic              last_step;

    assign rom_state = (state_q == S_FETCH) || (state_q == S_ROM_READ);
    assign ram_state = (state_q == S_RAM_READ) || (state_q == S_RAM_WRITE);
    assign bus_state = rom_state || ram_state;
    assign last_step = (step_q == step_t'(1));

    // a freshly fetched opcode starts from the decoder's step count
    assign step = (state_q == S_DECODE && step_q == '0) ? first_step : step_q;

    // ---------------------
    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (idle_cnt_q == '0) state_d = S_FETCH;
            S_FETCH:  if (slot_q) state_d = S_DECODE;
            S_DECODE: begin
                if (is_idle)             state_d = S_IDLE;
                else if (need_rom)       state_d = S_ROM_READ;
                else if (need_ram_read)  state_d = S_RAM_READ;
                else if (need_execute)   state_d = S_EXECUTE;
                else if (need_ram_write) state_d = S_RAM_WRITE;
                else                     state_d = S_FETCH;
            end
            S_ROM_READ, S_RAM_READ, S_RAM_WRITE: begin
                if (slot_q) state_d = last_step ? S_FETCH : S_DECODE;
            end
            S_EXECUTE: state_d = last_step ? S_FETCH : S_DECODE;
            default:   state_d = S_IDLE;
        endcase
    end

    // ---------------------
    // control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            slot_q     <= 1'b0;
            pc_q       <= reset_pc;
            ir_q       <= '0;          // reads as NOP
            step_q     <= '0;
            idle_cnt_q <= IDLE_LOAD;
        end else begin
            state_q <= state_d;
            slot_q  <= bus_state && !slot_q;
            case (state_q)
                S_IDLE: begin
                    if (idle_cnt_q != '0) idle_cnt_q <= idle_cnt_q - 1'b1;
                end
                S_FETCH: begin
                    if (slot_q) begin
                        ir_q   <= mem_rdata;
                        pc_q   <= pc_q + 1'b1;
                        step_q <= '0;
                    end
                end
                S_DECODE: begin
                    step_q     <= step;
                    idle_cnt_q <= IDLE_LOAD;   // used only if we drop into idle
                end
                S_ROM_READ: begin
                    if (slot_q) begin
                        pc_q   <= pc_q + 1'b1;
                        step_q <= step_q - 1'b1;
                    end
                end
                S_RAM_READ, S_RAM_WRITE: begin
                    if (slot_q) step_q <= step_q - 1'b1;
                end
                S_EXECUTE: begin
                    step_q <= step_q - 1'b1;
                    // sjmp offset is relative to the next instruction
                    if (opcode == OP_SJMP) pc_q <= pc_q + {{8{rom_q[7]}}, rom_q};
                end
                default: ;
            endcase
        end
    end

    // operand data registers
    always_ff @(posedge clk) begin
        if (state_q == S_ROM_READ && slot_q) rom_q <= mem_rdata;
        if (state_q == S_RAM_READ && slot_q) ram_q <= dir_hit ? dir_rdata : mem_rdata;
    end

    // ---------------------
    // bus and strobes
    assign mem_addr = ram_state ? {8'h00, rom_q} : pc_q;
    assign mem_sel  = ram_state && !dir_hit;
    assign mem_rd   = !slot_q && (rom_state || (state_q == S_RAM_READ && !dir_hit));
    assign mem_wr   = !slot_q && state_q == S_RAM_WRITE && !dir_hit;

    assign exec_stb = (state_q == S_EXECUTE);
    assign wb_stb   = (state_q == S_RAM_WRITE) && !slot_q;  // sfr write slot

    assign opcode   = opcode_e'(ir_q);
    assign rom_data = rom_q;
    assign ram_data = ram_q;
    assign dir_addr = rom_q;   // direct operand is always the rom byte

endmodule

`default_nettype wire

// File: logic/insn_decoder.sv
// --------------------
// steps run in the fixed order rom read, ram read, execute, ram write
// --------------------
`default_nettype none
`timescale 1ns/100ps

module insn_decoder
    import cpu_pkg::*;
(
    input  opcode_e opcode,
    input  step_t   step,           // remaining steps
    output step_t   first_step,
    output logic    need_rom,
    output logic    need_ram_read,
    output logic    need_execute,
    output logic    need_ram_write,
    output logic    is_idle,
    output src_e    a_src,
    output src_e    b_src,
    output alu_op_e alu_op
);

    logic uses_rom;
    logic uses_rd;
    logic uses_ex;
    logic uses_wr;

    always_comb begin
        uses_rom = 1'b0;
        uses_rd  = 1'b0;
        uses_ex  = 1'b0;
        uses_wr  = 1'b0;
        a_src    = SRC_NONE;
        b_src    = SRC_NONE;
        case (opcode)
            OP_INC_A, OP_CPL_A: begin
                uses_ex = 1'b1;
                a_src   = SRC_A;
            end
            OP_ADD_IMM, OP_ORL_IMM, OP_ANL_IMM, OP_XRL_IMM,
            OP_MOV_A_IMM, OP_SUBB_IMM: begin
                uses_rom = 1'b1;
                uses_ex  = 1'b1;
                a_src    = SRC_A;
                b_src    = SRC_ROM;
            end
            OP_ADD_DIR, OP_MOV_A_DIR: begin
                uses_rom = 1'b1;
                uses_rd  = 1'b1;
                uses_ex  = 1'b1;
                a_src    = SRC_A;
                b_src    = SRC_RAM;
            end
            OP_SJMP: begin          // pc update happens in the sequencer
                uses_rom = 1'b1;
                uses_ex  = 1'b1;
            end
            OP_MOV_DIR_A: begin
                uses_rom = 1'b1;
                uses_wr  = 1'b1;
            end
            default: ;              // nop and unknown opcodes
        endcase
    end

    always_comb begin
        case (opcode)
            OP_INC_A:                alu_op = ALU_INC;
            OP_CPL_A:                alu_op = ALU_CPL;
            OP_ADD_IMM, OP_ADD_DIR:  alu_op = ALU_ADD;
            OP_SUBB_IMM:             alu_op = ALU_SUBB;
            OP_ANL_IMM:              alu_op = ALU_AND;
            OP_ORL_IMM:              alu_op = ALU_OR;
            OP_XRL_IMM:              alu_op = ALU_XOR;
            default:                 alu_op = ALU_PASS_B;   // movs and sjmp
        endcase
    end

    assign first_step = step_t'(uses_rom) + step_t'(uses_rd) + step_t'(uses_ex)
                      + step_t'(uses_wr);
    assign is_idle    = (first_step == '0);

    // position of each step counted from the end of the list
    assign need_ram_write = uses_wr && (step == step_t'(1));
    assign need_execute   = uses_ex && (step == step_t'(1) + step_t'(uses_wr));
    assign need_ram_read  = uses_rd
                          && (step == step_t'(1) + step_t'(uses_wr) + step_t'(uses_ex));
    assign need_rom       = uses_rom && (step == first_step);

endmodule

`default_nettype wire

// File: logic/core_regs.sv
// --------------------
// A, B, PSW; the PSW parity bit is always recomputed from A
// --------------------
`default_nettype none
`timescale 1ns/100ps

module core_regs
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      exec_stb,
    input  logic      wb_stb,
    input  src_e      a_src,
    input  src_e      b_src,
    input  byte_t     rom_data,
    input  byte_t     ram_data,
    input  dir_addr_t dir_addr,
    input  byte_t     alu_result,
    input  logic      alu_cy,
    output byte_t     a_val,
    output byte_t     b_val,
    output logic      cy,
    output logic      dir_hit,
    output byte_t     dir_rdata,
    output byte_t     wdata
);

    byte_t acc_q;
    byte_t b_q;
    byte_t psw_q;
    byte_t psw_view;   // psw as seen by reads

    function automatic byte_t pick(input src_e src, input byte_t acc, input byte_t ram,
                                   input byte_t rom);
        case (src)
            SRC_A:   pick = acc;
            SRC_RAM: pick = ram;
            SRC_ROM: pick = rom;
            default: pick = '0;
        endcase
    endfunction

    assign a_val = pick(a_src, acc_q, ram_data, rom_data);
    assign b_val = pick(b_src, acc_q, ram_data, rom_data);

    always_comb begin
        psw_view        = psw_q;
        psw_view[P_BIT] = ^acc_q;   // odd number of ones
    end

    assign cy      = psw_q[CY_BIT];
    assign wdata   = acc_q;
    assign dir_hit = (dir_addr == ACC_ADDR) || (dir_addr == B_ADDR) || (dir_addr == PSW_ADDR);

    always_comb begin
        case (dir_addr)
            ACC_ADDR: dir_rdata = acc_q;
            B_ADDR:   dir_rdata = b_q;
            PSW_ADDR: dir_rdata = psw_view;
            default:  dir_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            b_q   <= '0;
            psw_q <= '0;
        end else if (exec_stb && a_src == SRC_A) begin
            acc_q         <= alu_result;
            psw_q[CY_BIT] <= alu_cy;
        end else if (wb_stb && dir_hit) begin
            // mov direct,A to an sfr; E0h leaves A as it is
            case (dir_addr)
                B_ADDR:   b_q   <= acc_q;
                PSW_ADDR: psw_q <= acc_q;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
// --------------------
// combinational 8-bit alu, only ADD and SUBB touch the carry
// --------------------
`default_nettype none
`timescale 1ns/100ps

module alu
    import cpu_pkg::*;
(
    input  byte_t   a,
    input  byte_t   b,
    input  logic    cy_in,
    input  alu_op_e op,
    output byte_t   result,
    output logic    cy_out
);

    logic [8:0] sum;    // carry out in bit 8
    logic [8:0] diff;   // borrow in bit 8

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b} - {8'h00, cy_in};

    always_comb begin
        result = b;
        cy_out = cy_in;
        case (op)
            ALU_PASS_B: result = b;
            ALU_ADD: begin
                result = sum[7:0];
                cy_out = sum[8];
            end
            ALU_SUBB: begin
                result = diff[7:0];
                cy_out = diff[8];
            end
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_INC:    result = a + 8'h01;   // wraps, carry untouched as on 8051
            ALU_CPL:    result = ~a;
            default:    result = b;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
// --------------------
// shared types for the 8-bit accumulator core (8051 subset)
// unknown opcodes keep their raw value in opcode_e and decode as NOP
// --------------------
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;      // one data byte
    typedef logic [15:0] addr_t;      // memory address
    typedef logic [7:0]  dir_addr_t;  // 8051 direct address
    typedef logic [2:0]  step_t;      // remaining execution steps

    // kept opcodes, 8051 encoding
    typedef enum logic [7:0] {
        OP_NOP       = 8'h00,
        OP_INC_A     = 8'h04,
        OP_ADD_IMM   = 8'h24,
        OP_ADD_DIR   = 8'h25,
        OP_ORL_IMM   = 8'h44,
        OP_ANL_IMM   = 8'h54,
        OP_XRL_IMM   = 8'h64,
        OP_MOV_A_IMM = 8'h74,
        OP_SJMP      = 8'h80,
        OP_SUBB_IMM  = 8'h94,
        OP_MOV_A_DIR = 8'hE5,
        OP_CPL_A     = 8'hF4,
        OP_MOV_DIR_A = 8'hF5
    } opcode_e;

    // one-hot sequencer states
    typedef enum logic [6:0] {
        S_IDLE      = 7'b000_0001,
        S_FETCH     = 7'b000_0010,
        S_DECODE    = 7'b000_0100,
        S_ROM_READ  = 7'b000_1000,
        S_RAM_READ  = 7'b001_0000,
        S_EXECUTE   = 7'b010_0000,
        S_RAM_WRITE = 7'b100_0000
    } seq_state_e;

    // operand source; for operand a this is also the destination
    typedef enum logic [1:0] {
        SRC_A    = 2'd0,
        SRC_RAM  = 2'd1,
        SRC_ROM  = 2'd2,
        SRC_NONE = 2'd3
    } src_e;

    typedef enum logic [2:0] {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUBB   = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_XOR    = 3'd5,
        ALU_INC    = 3'd6,
        ALU_CPL    = 3'd7
    } alu_op_e;

    // ---------------------
    // SFR direct addresses served inside the core
    localparam dir_addr_t ACC_ADDR = 8'hE0;
    localparam dir_addr_t B_ADDR   = 8'hF0;
    localparam dir_addr_t PSW_ADDR = 8'hD0;

    localparam int CY_BIT = 7;  // carry in PSW
    localparam int P_BIT  = 0;  // parity in PSW

endpackage

`default_nettype wire
